//--- dual_dac_stim.txt
# name in_a a_valid in_b b_valid gain_a gain_b offset_a offset_b
# expected: dac_data(hex) dac_valid clip_a clip_b  (rand lines: samples drawn in testbench)
idle0 0 0 0 0 16384 16384 0 0 00000000 0 0 0
a_only 4000 1 0 0 16384 16384 0 0 0FA00000 0 0 0
a_hold 0 0 0 0 16384 16384 0 0 0FA00000 0 0 0
a_neg -4000 1 0 0 16384 16384 0 0 F0600000 0 0 0
a_hold2 0 0 0 0 16384 16384 0 0 F0600000 0 0 0
b_first 0 0 800 1 16384 16384 0 0 F0600320 0 0 0
valid_up 0 0 0 0 16384 16384 0 0 F0600320 1 0 0
b_hold 0 0 0 0 16384 16384 0 0 F0600320 1 0 0
b_neg 0 0 -7 1 16384 16384 0 0 F060FFF9 1 0 0
a_hi_clip 32767 1 0 0 16384 16384 0 0 1FFFFFF9 1 1 0
a_lo_clip -32768 1 0 0 16384 16384 0 0 E000FFF9 1 1 0
clip_done 0 0 0 0 16384 16384 0 0 E000FFF9 1 0 0
cfg2 0 0 0 0 8192 -16384 100 -50 E000FFF9 1 0 0
gain_pos 1000 1 1000 1 8192 -16384 100 -50 0258FBE6 1 0 0
gain_neg -1001 1 -3 1 8192 -16384 100 -50 FE6FFFD1 1 0 0
gain_hold 0 0 0 0 8192 -16384 100 -50 FE6FFFD1 1 0 0
cfg3 0 0 0 0 20000 16384 0 -8000 FE6FFFD1 1 0 0
sat_both 20000 1 -1000 1 20000 16384 0 -8000 1FFFE000 1 1 1
sat_near 6000 1 800 1 20000 16384 0 -8000 1C9CE3E0 1 0 0
sat_a_lo -7000 1 0 0 20000 16384 0 -8000 E000E3E0 1 1 0
sat_hold 0 0 0 0 20000 16384 0 -8000 E000E3E0 1 0 0
cfg_unity 0 0 0 0 16384 16384 0 0 E000E3E0 1 0 0
b2b_1 100 1 200 1 16384 16384 0 0 006400C8 1 0 0
b2b_2 -100 1 -200 1 16384 16384 0 0 FF9CFF38 1 0 0
b2b_edge 8191 1 -8192 1 16384 16384 0 0 1FFFE000 1 0 0
b2b_4 5 1 -5 1 16384 16384 0 0 0005FFFB 1 0 0
b2b_a -1 1 0 0 16384 16384 0 0 FFFFFFFB 1 0 0
b2b_b 0 0 8 1 16384 16384 0 0 FFFF0008 1 0 0
b2b_hold 0 0 0 0 16384 16384 0 0 FFFF0008 1 0 0
rand 0 1 0 1 12000 -20000 300 -200 00000000 1 0 0
rand 0 1 0 1 12000 -20000 300 -200 00000000 1 0 0
rand 0 1 0 1 12000 -20000 300 -200 00000000 1 0 0
rand 0 1 0 1 12000 -20000 300 -200 00000000 1 0 0
rand 0 1 0 0 12000 -20000 300 -200 00000000 1 0 0
rand 0 1 0 1 12000 -20000 300 -200 00000000 1 0 0
rand 0 1 0 1 12000 -20000 300 -200 00000000 1 0 0
rand 0 1 0 1 12000 -20000 300 -200 00000000 1 0 0
rand 0 0 0 1 12000 -20000 300 -200 00000000 1 0 0
rand 0 1 0 1 12000 -20000 300 -200 00000000 1 0 0
rand 0 1 0 1 12000 -20000 300 -200 00000000 1 0 0
rand 0 1 0 1 12000 -20000 300 -200 00000000 1 0 0
rand 0 1 0 1 12000 -20000 300 -200 00000000 1 0 0
rand 0 0 0 0 12000 -20000 300 -200 00000000 1 0 0
rand 0 1 0 1 12000 -20000 300 -200 00000000 1 0 0
rand 0 1 0 1 12000 -20000 300 -200 00000000 1 0 0
rand 0 1 0 1 12000 -20000 300 -200 00000000 1 0 0
rand 0 0 0 0 12000 -20000 300 -200 00000000 1 0 0

//--- list.f
dac_pkg.sv
channel_scaler.sv
signal_combine.sv
dual_dac_top.sv
dual_dac_chk.sv
tb_dual_dac.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the dual DAC testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
EXE=sim_dual_dac

# Compile
verilator --binary --timing --assert \
    --top-module tb_dual_dac \
    --Mdir "$OBJ" -o "$EXE" \
    -f list.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# Run
"./$OBJ/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Verdict from the log
if grep -q "Test FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if ! grep -q "Test OK" "$LOG"; then
    echo "Simulation ended without a verdict"
    exit 1
fi

exit 0

//--- tb_dual_dac.sv
`default_nettype none

module tb_dual_dac import dac_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    // DUT side
    logic    s1_clk;
    logic    rst;
    sample_t in_a;
    logic    in_a_valid;
    sample_t in_b;
    logic    in_b_valid;
    sample_t gain_a;
    sample_t gain_b;
    sample_t offset_a;
    sample_t offset_b;
    stream_t dac_data;
    logic    dac_valid;
    logic    clip_a;
    logic    clip_b;

    // Bookkeeping
    int errors;
    int checks;
    int seed;
    int fd;
    int n;
    int lines;
    string line;
    string name;
    int a, av, b, bv, ga, gb, oa, ob, ev, eca, ecb;
    logic [31:0] exp_word;
    logic [15:0] half_a;
    logic [15:0] half_b;
    logic clip_hit;

    // Expected values trail the drive by three cycles
    string       name_q[$];
    logic [31:0] data_q[$];
    int          valid_q[$];
    int          ca_q[$];
    int          cb_q[$];

    dual_dac_top uut (
        .s1_clk     (s1_clk),
        .rst        (rst),
        .in_a       (in_a),
        .in_a_valid (in_a_valid),
        .in_b       (in_b),
        .in_b_valid (in_b_valid),
        .gain_a     (gain_a),
        .gain_b     (gain_b),
        .offset_a   (offset_a),
        .offset_b   (offset_b),
        .dac_data   (dac_data),
        .dac_valid  (dac_valid),
        .clip_a     (clip_a),
        .clip_b     (clip_b)
    );

    bind dual_dac_top dual_dac_chk u_chk (
        .s1_clk    (s1_clk),
        .rst       (rst),
        .dac_data  (dac_data),
        .dac_valid (dac_valid),
        .clip_a    (clip_a),
        .clip_b    (clip_b)
    );

    // 40 ns period
    initial
    begin
        s1_clk = 1'b0;
        forever #20 s1_clk = ~s1_clk;
    end

    ////////////////////
    // Helpers
    ////////////////////

    // Q2.14 gain then floor shift, offset and clamp to 14 bits
    function automatic logic [15:0] scale_half(input int sample, input int gain,
                                               input int offset, output logic clipped);
        int sum;
        sum = ((sample * gain) >>> gain_frac_bits) + offset;
        clipped = 1'b1;
        if (sum > dac_max)
            sum = dac_max;
        else if (sum < dac_min)
            sum = dac_min;
        else
            clipped = 1'b0;
        return 16'(sum);
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            $display("[ERROR] %s: expected %h, actual %h", what, expected, actual);
            errors++;
        end
    endtask

    // Inputs change on the rising edge
    task automatic drive_vector();
        in_a       <= sample_t'(a);
        in_a_valid <= (av != 0);
        in_b       <= sample_t'(b);
        in_b_valid <= (bv != 0);
        gain_a     <= sample_t'(ga);
        gain_b     <= sample_t'(gb);
        offset_a   <= sample_t'(oa);
        offset_b   <= sample_t'(ob);
    endtask

    task automatic check_oldest();
        string nm;
        nm = name_q.pop_front();
        check_value({nm, " dac_data"}, data_q.pop_front(), dac_data);
        check_value({nm, " dac_valid"}, 32'(valid_q.pop_front()), 32'(dac_valid));
        check_value({nm, " clip_a"}, 32'(ca_q.pop_front()), 32'(clip_a));
        check_value({nm, " clip_b"}, 32'(cb_q.pop_front()), 32'(clip_b));
    endtask

    task automatic wait_dac_valid(input int limit);
        int cycles;
        cycles = 0;
        while (dac_valid !== 1'b1 && cycles < limit)
        begin
            @(negedge s1_clk);
            cycles++;
        end
        if (dac_valid !== 1'b1)
        begin
            $display("Timeout: dac_valid did not go high within %0d cycles", limit);
            errors++;
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial
    begin
        errors = 0;
        checks = 0;
        seed = 90;
        lines = 0;
        half_a = '0;
        half_b = '0;
        rst = 1'b1;
        in_a = '0;
        in_a_valid = 1'b0;
        in_b = '0;
        in_b_valid = 1'b0;
        gain_a = '0;
        gain_b = '0;
        offset_a = '0;
        offset_b = '0;

        repeat (10) @(posedge s1_clk);
        rst <= 1'b0;
        @(negedge s1_clk);
        check_value("reset dac_data", 32'h0, dac_data);
        check_value("reset dac_valid", 32'h0, 32'(dac_valid));
        check_value("reset clip_a", 32'h0, 32'(clip_a));
        check_value("reset clip_b", 32'h0, 32'(clip_b));

        fd = $fopen("dual_dac_stim.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file dual_dac_stim.txt");
            errors++;
        end
        else
        begin
            while (!$feof(fd) && lines < 1000)
            begin
                lines++;
                n = $fgets(line, fd);
                if (n == 0 || line.len() < 2 || line.substr(0, 0) == "#")
                    continue;
                n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %h %d %d %d", name,
                            a, av, b, bv, ga, gb, oa, ob, exp_word, ev, eca, ecb);
                if (n != 13)
                begin
                    $display("Stimulus line %0d could not be parsed", lines);
                    errors++;
                    continue;
                end
                // Random lines draw their samples and expected words here
                if (name == "rand")
                begin
                    eca = 0;
                    ecb = 0;
                    if (av != 0)
                    begin
                        a = int'(sample_t'($random(seed)));
                        half_a = scale_half(a, ga, oa, clip_hit);
                        eca = int'(clip_hit);
                    end
                    if (bv != 0)
                    begin
                        b = int'(sample_t'($random(seed)));
                        half_b = scale_half(b, gb, ob, clip_hit);
                        ecb = int'(clip_hit);
                    end
                    exp_word = {half_a, half_b};
                end
                else
                begin
                    // Fixed lines carry the full word for later random lines
                    half_a = exp_word[31:16];
                    half_b = exp_word[15:0];
                end
                @(posedge s1_clk);
                drive_vector();
                name_q.push_back(name);
                data_q.push_back(exp_word);
                valid_q.push_back(ev);
                ca_q.push_back(eca);
                cb_q.push_back(ecb);
                @(negedge s1_clk);
                if (data_q.size() > 3)
                    check_oldest();
            end
            $fclose(fd);

            // Drain the last three vectors
            repeat (3)
            begin
                @(posedge s1_clk);
                in_a_valid <= 1'b0;
                in_b_valid <= 1'b0;
                @(negedge s1_clk);
                if (data_q.size() > 0)
                    check_oldest();
            end
            wait_dac_valid(20);
        end

        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dual_dac_chk.sv
`default_nettype none

// Bound checker for the DAC top level
module dual_dac_chk import dac_pkg::*;
(
    input wire logic    s1_clk,
    input wire logic    rst,
    input wire stream_t dac_data,
    input wire logic    dac_valid,
    input wire logic    clip_a,
    input wire logic    clip_b
);
    timeunit 1ns;
    timeprecision 1ps;

    // Saturation codes sign-extended to a half word
    localparam half_t half_max = half_t'(dac_max);
    localparam half_t half_min = half_t'(dac_min);

    ////////////////////
    // Valid rules
    ////////////////////

    // Still low one edge after reset release
    assert property (@(posedge s1_clk) $fell(rst) |=> !dac_valid)
        else $error("dac_valid high in the first cycle after reset");

    // Sticky until the next reset
    assert property (@(posedge s1_clk) disable iff (rst) !$fell(dac_valid))
        else $error("dac_valid fell outside reset");

    ////////////////////
    // Clip rules
    ////////////////////

    // Clip pulse only with a saturated half
    assert property (@(posedge s1_clk) disable iff (rst)
        clip_a |-> (dac_data[31:16] == half_max || dac_data[31:16] == half_min))
        else $error("clip_a without a saturated high half");

    assert property (@(posedge s1_clk) disable iff (rst)
        clip_b |-> (dac_data[15:0] == half_max || dac_data[15:0] == half_min))
        else $error("clip_b without a saturated low half");

endmodule

`default_nettype wire

//--- dual_dac_top.sv
`default_nettype none

// Two-channel DAC feed
// Strobe to matching half of dac_data is 3 cycles
module dual_dac_top import dac_pkg::*;
(
    input  wire logic    s1_clk,
    input  wire logic    rst,
    input  wire sample_t in_a,
    input  wire logic    in_a_valid,
    input  wire sample_t in_b,
    input  wire logic    in_b_valid,
    input  wire sample_t gain_a,
    input  wire sample_t gain_b,
    input  wire sample_t offset_a,
    input  wire sample_t offset_b,
    output stream_t      dac_data,
    output logic         dac_valid,
    output logic         clip_a,
    output logic         clip_b
);

    ////////////////////
    // Channel links
    ////////////////////

    stream_t chan_a_data;
    logic    chan_a_valid;
    logic    chan_a_clip;

    stream_t chan_b_data;
    logic    chan_b_valid;
    logic    chan_b_clip;

    // Channel A scaler
    channel_scaler u_chan_a (
        .s1_clk    (s1_clk),
        .rst       (rst),
        .in_data   (in_a),
        .in_valid  (in_a_valid),
        .gain      (gain_a),
        .offset    (offset_a),
        .out_data  (chan_a_data),
        .out_valid (chan_a_valid),
        .out_clip  (chan_a_clip)
    );

    // Channel B scaler, same pipeline depth as A
    channel_scaler u_chan_b (
        .s1_clk    (s1_clk),
        .rst       (rst),
        .in_data   (in_b),
        .in_valid  (in_b_valid),
        .gain      (gain_b),
        .offset    (offset_b),
        .out_data  (chan_b_data),
        .out_valid (chan_b_valid),
        .out_clip  (chan_b_clip)
    );

    // Packs both channels into the DAC word
    signal_combine u_combine (
        .s1_clk    (s1_clk),
        .rst       (rst),
        .a_data    (chan_a_data),
        .a_valid   (chan_a_valid),
        .a_clip    (chan_a_clip),
        .b_data    (chan_b_data),
        .b_valid   (chan_b_valid),
        .b_clip    (chan_b_clip),
        .dac_data  (dac_data),
        .dac_valid (dac_valid),
        .clip_a    (clip_a),
        .clip_b    (clip_b)
    );

endmodule

`default_nettype wire

//--- signal_combine.sv
`default_nettype none

// Holds the newest word from each channel
// and packs both into one DAC word
module signal_combine import dac_pkg::*;
(
    input  wire logic    s1_clk,
    input  wire logic    rst,
    input  wire stream_t a_data,
    input  wire logic    a_valid,
    input  wire logic    a_clip,
    input  wire stream_t b_data,
    input  wire logic    b_valid,
    input  wire logic    b_clip,
    output stream_t      dac_data,
    output logic         dac_valid,
    output logic         clip_a,
    output logic         clip_b
);

    // Latest sample per channel
    stream_t held_a;
    stream_t held_b;

    // Set once a channel has delivered anything
    logic seen_a;
    logic seen_b;

    // Top adc_width bits of a stream word, sign-extended to a half word
    function automatic half_t pack_half(input stream_t word);
        return {{ext_width{word[stream_width-1]}},
                word[stream_width-1:stream_width-adc_width]};
    endfunction

    ////////////////////
    // Hold registers
    ////////////////////

    // Cleared on reset so the DAC sees mid-scale zero
    // New sample simply overwrites the old one
    always_ff @(posedge s1_clk)
    begin
        if (rst)
        begin
            held_a <= '0;
            held_b <= '0;
            seen_a <= 1'b0;
            seen_b <= 1'b0;
            dac_valid <= 1'b0;
            clip_a <= 1'b0;
            clip_b <= 1'b0;
        end
        else
        begin
            if (a_valid)
            begin
                held_a <= a_data;
                seen_a <= 1'b1;
            end
            if (b_valid)
            begin
                held_b <= b_data;
                seen_b <= 1'b1;
            end
            // One cycle behind both seen flags, sticky till reset
            dac_valid <= seen_a & seen_b;
            // Same edge as the hold load, so pulse lines up with data
            clip_a <= a_valid & a_clip;
            clip_b <= b_valid & b_clip;
        end
    end

    // Channel A high, channel B low
    assign dac_data = {pack_half(held_a), pack_half(held_b)};

endmodule

`default_nettype wire

//--- channel_scaler.sv
`default_nettype none

// Per-channel gain, offset and saturation
// Two register stages, so in_valid at one edge
// shows up on out_valid two edges later
module channel_scaler import dac_pkg::*;
(
    input  wire logic    s1_clk,
    input  wire logic    rst,
    input  wire sample_t in_data,
    input  wire logic    in_valid,
    input  wire sample_t gain,
    input  wire sample_t offset,
    output stream_t      out_data,
    output logic         out_valid,
    output logic         out_clip
);

    ////////////////////
    // Stage 1 multiply
    ////////////////////

    // Full-width signed product
    product_t product_s1;
    logic     valid_s1;

    // Stage 2 combinational terms
    product_t scaled;
    product_t sum;
    dac_t     sat_code;
    logic     sat_hit;

    // Product register
    always_ff @(posedge s1_clk)
    begin
        product_s1 <= in_data * gain;
    end

    // Valid pipe, stage 1
    always_ff @(posedge s1_clk)
    begin
        if (rst)
        begin
            valid_s1 <= 1'b0;
        end
        else
        begin
            valid_s1 <= in_valid;
        end
    end

    ////////////////////
    // Stage 2 scale
    ////////////////////

    // Drop the Q2.14 fraction
    // Arithmetic shift rounds toward minus infinity
    // Offset is sign-extended by the signed add
    always_comb
    begin
        scaled = product_s1 >>> gain_frac_bits;
        sum    = scaled + offset;
    end

    // Clamp to the DAC range
    always_comb
    begin
        if (sum > dac_max)
        begin
            sat_code = dac_t'(dac_max);
            sat_hit  = 1'b1;
        end
        else if (sum < dac_min)
        begin
            sat_code = dac_t'(dac_min);
            sat_hit  = 1'b1;
        end
        else
        begin
            // Low bits already hold the in-range code
            sat_code = sum[adc_width-1:0];
            sat_hit  = 1'b0;
        end
    end

    ////////////////////
    // Output register
    ////////////////////

    // Code sits at the top of the word with zeros below
    always_ff @(posedge s1_clk)
    begin
        out_data <= {sat_code, {pad_width{1'b0}}};
    end

    // Valid and clip pulse together
    always_ff @(posedge s1_clk)
    begin
        if (rst)
        begin
            out_valid <= 1'b0;
            out_clip  <= 1'b0;
        end
        else
        begin
            out_valid <= valid_s1;
            // Only flag clipping on a real sample
            out_clip  <= valid_s1 & sat_hit;
        end
    end

endmodule

`default_nettype wire

//--- dac_pkg.sv
`default_nettype none

package dac_pkg;

    ////////////////////
    // Widths
    ////////////////////

    // Input samples, gains and offsets
    localparam int sample_width = 16;

    // DAC resolution in bits
    localparam int adc_width = 14;

    // One half of the packed DAC word
    localparam int adc_data_width = 16;

    // Stream word between scaler and combiner
    localparam int stream_width = 32;

    // Full multiplier result
    localparam int product_width = 2 * sample_width;

    // Zero fill below the MSB-aligned DAC code
    localparam int pad_width = stream_width - adc_width;

    // Sign bits added when packing a 14-bit code into a half word
    localparam int ext_width = adc_data_width - adc_width;

    ////////////////////
    // Fixed point
    ////////////////////

    // Gain is signed Q2.14, so 16384 is unity
    localparam int gain_frac_bits = 14;

    // Saturation limits of the 14-bit DAC
    localparam int dac_max = 8191;
    localparam int dac_min = -8192;

    ////////////////////
    // Types
    ////////////////////

    typedef logic signed [sample_width-1:0]  sample_t;
    typedef logic        [stream_width-1:0]  stream_t;
    typedef logic signed [product_width-1:0] product_t;
    typedef logic signed [adc_width-1:0]     dac_t;
    typedef logic        [adc_data_width-1:0] half_t;

endpackage

`default_nettype wire
